/* Makefile */
TOP = tb_vga_linear
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)
	verilator --lint-only -f tb.f --top-module vga_linear_top

clean:
	rm -rf obj_dir $(LOG)

/* dv/tb_vga_linear.sv */
/*
 * Testbench for the VGA linear scan-out
 * Frame-buffer model, palette load, table of pixel checks and
 * raster geometry checks from the output side only
 */

`timescale 1ns/10ps

module tb_vga_linear;

  localparam int FB_BYTES  = 64000;
  localparam int STB_FRAME = vga_pkg::V_ACTIVE * vga_pkg::H_VISIBLE / 2;
  localparam int TIMEOUT   = 2 * vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;

  logic clk;
  logic rst;
  logic mode_en_i;
  logic [vga_pkg::ADR_W-1:0] mem_adr_o;
  logic mem_stb_o;
  logic [vga_pkg::DAT_W-1:0] mem_dat_i;
  logic pal_we_i;
  logic [vga_pkg::IDX_W-1:0] pal_idx_i;
  logic [vga_pkg::RGB_W-1:0] pal_dat_i;
  logic [vga_pkg::RGB_W-1:0] rgb_o;
  logic hsync_o;
  logic vsync_o;
  logic de_o;

  logic [7:0]                fb [FB_BYTES];
  logic [vga_pkg::RGB_W-1:0] pal_copy [vga_pkg::PAL_DEPTH];
  logic [vga_pkg::DAT_W-1:0] dly_q [vga_pkg::MEM_LAT-1];

  // Stimulus table columns
  string t_name[$];
  int    t_frame[$];
  int    t_line[$];
  int    t_col[$];
  bit    t_dbl[$];
  bit    t_upd[$];

  // Output position tracker, sampled at the falling edge
  int col = 0;
  int line_cnt = 0;
  int cur_line = 0;
  int frame_cnt = 0;
  int hs_cnt = 0;
  bit prev_de = 0;
  bit prev_vs = 1;
  bit prev_hs = 1;
  bit seen_hs = 0;
  bit de_s = 0;
  logic [vga_pkg::RGB_W-1:0] rgb_s = '0;
  int geom_err = 0;

  int stb_cnt = 0;
  int stb_frame = 0;
  int mem_err = 0;

  vga_linear_top uut (.*);

  always #20 clk = ~clk;

  // Frame-buffer model, chain-4 byte index is the address over two
  always @(posedge clk)
  begin
    int badr;
    logic [vga_pkg::DAT_W-1:0] word;
    badr = int'(mem_adr_o) >> 1;
    word = '0;
    if (frame_cnt != stb_frame)
    begin
      if (stb_cnt != STB_FRAME)
      begin
        $display("ERR strobe_count expected %0d actual %0d", STB_FRAME, stb_cnt);
        mem_err++;
      end
      stb_cnt   = 0;
      stb_frame = frame_cnt;
    end
    if (mem_stb_o)
    begin
      stb_cnt++;
      if (badr >= FB_BYTES)
      begin
        $display("Strobe address %0h beyond the frame buffer", mem_adr_o);
        mem_err++;
      end
      else
        word = {~fb[badr], fb[badr]};
      if (line_cnt == vga_pkg::V_ACTIVE)
      begin
        $display("Strobe issued during vertical blanking");
        mem_err++;
      end
    end
    mem_dat_i <= dly_q[vga_pkg::MEM_LAT-2];
    for (int i = vga_pkg::MEM_LAT - 2; i > 0; i--)
      dly_q[i] <= dly_q[i-1];
    dly_q[0] <= word;
  end

  // Tracker and line geometry checks
  always @(negedge clk)
  begin
    if (!rst)
    begin
      rgb_s = rgb_o;
      de_s  = de_o;
      if (de_o)
      begin
        if (!prev_de)
        begin
          col      = 0;
          cur_line = line_cnt;
        end
        else
          col++;
      end
      else if (prev_de)
      begin
        if (col + 1 != vga_pkg::H_VISIBLE)
        begin
          $display("ERR line_length expected %0d actual %0d", vga_pkg::H_VISIBLE, col + 1);
          geom_err++;
        end
        line_cnt++;
      end
      // Frame boundary on the vsync falling edge
      if (!vsync_o && prev_vs)
      begin
        if (line_cnt != vga_pkg::V_ACTIVE)
        begin
          $display("ERR line_count expected %0d actual %0d", vga_pkg::V_ACTIVE, line_cnt);
          geom_err++;
        end
        line_cnt = 0;
        frame_cnt++;
      end
      hs_cnt++;
      if (!hsync_o && prev_hs)
      begin
        if (seen_hs && hs_cnt != vga_pkg::H_TOTAL)
        begin
          $display("ERR hsync_period expected %0d actual %0d", vga_pkg::H_TOTAL, hs_cnt);
          geom_err++;
        end
        seen_hs = 1;
        hs_cnt  = 0;
      end
      prev_de = de_o;
      prev_vs = vsync_o;
      prev_hs = hsync_o;
    end
  end

  task automatic add_test(input string name, input int f, input int y, input int x,
                          input bit dbl, input bit upd);
    t_name.push_back(name);
    t_frame.push_back(f);
    t_line.push_back(y);
    t_col.push_back(x);
    t_dbl.push_back(dbl);
    t_upd.push_back(upd);
  endtask

  task automatic write_palette(input int idx, input logic [vga_pkg::RGB_W-1:0] dat);
    @(posedge clk);
    pal_we_i  <= 1'b1;
    pal_idx_i <= idx[vga_pkg::IDX_W-1:0];
    pal_dat_i <= dat;
    @(posedge clk);
    pal_we_i  <= 1'b0;
    pal_copy[idx] = dat;
  endtask

  // Waits for the tracker to reach a pixel
  task automatic wait_pixel(input int f, input int y, input int x, output bit ok);
    ok = 0;
    for (int n = 0; n < TIMEOUT && !ok; n++)
    begin
      @(posedge clk);
      if (de_s && frame_cnt == f && cur_line == y && col == x)
        ok = 1;
    end
  endtask

  // Waits for the vertical blanking of frame f
  task automatic wait_blank(input int f, output bit ok);
    ok = 0;
    for (int n = 0; n < TIMEOUT && !ok; n++)
    begin
      @(posedge clk);
      if (frame_cnt == f && line_cnt == vga_pkg::V_ACTIVE)
        ok = 1;
    end
  endtask

  initial
  begin
    bit ok;
    bit timed_out;
    int errors;
    int fails;
    int bad;
    int idx;
    logic [vga_pkg::RGB_W-1:0] exp_rgb;
    logic [vga_pkg::RGB_W-1:0] prev_rgb;
    logic [vga_pkg::RGB_W-1:0] new_rgb;
    void'($urandom(93));
    clk = 0;
    rst = 1;
    mode_en_i = 0;
    mem_dat_i = '0;
    pal_we_i = 0;
    pal_idx_i = '0;
    pal_dat_i = '0;
    timed_out = 0;
    errors = 0;
    fails = 0;
    prev_rgb = '0;
    for (int i = 0; i < FB_BYTES; i++)
      fb[i] = 8'($urandom);
    for (int i = 0; i < vga_pkg::MEM_LAT - 1; i++)
      dly_q[i] = '0;
    // Name, frame, line, column, doubling, palette rewrite
    add_test("px_origin", 0, 0, 0, 0, 0);
    add_test("dbl_col_0", 0, 0, 1, 1, 0);
    add_test("dbl_line_0", 0, 1, 1, 1, 0);
    add_test("px_mid", 0, 36, 100, 0, 0);
    add_test("dbl_col_mid", 0, 36, 101, 1, 0);
    add_test("dbl_line_mid", 0, 37, 101, 1, 0);
    add_test("px_center", 0, 200, 319, 0, 0);
    add_test("px_last", 0, 399, 638, 0, 0);
    add_test("dbl_col_last", 0, 399, 639, 1, 0);
    add_test("pal_update", 1, 50, 200, 0, 1);
    add_test("pal_dbl_col", 1, 50, 201, 1, 0);
    add_test("pal_dbl_line", 1, 51, 201, 1, 0);
    add_test("px_frame1", 1, 120, 7, 0, 0);
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    // Idle raster before the mode is enabled
    bad = 0;
    repeat (20)
    begin
      @(posedge clk);
      if (mem_stb_o || de_o || !hsync_o || !vsync_o)
        bad++;
    end
    if (bad != 0)
    begin
      $display("Outputs active before mode enable on %0d cycles", bad);
      errors++;
      fails++;
    end
    $display("test idle_before_enable %s", (bad == 0) ? "ok" : "failed");

    for (int i = 0; i < vga_pkg::PAL_DEPTH; i++)
      write_palette(i, vga_pkg::RGB_W'($urandom));
    @(posedge clk);
    mode_en_i <= 1'b1;

    foreach (t_name[i])
    begin
      bad = 0;
      idx = fb[(t_line[i] / 2) * 320 + t_col[i] / 2];
      if (t_upd[i])
      begin
        wait_blank(t_frame[i] - 1, ok);
        if (!ok)
        begin
          $display("Timeout waiting for blanking before test %s", t_name[i]);
          timed_out = 1;
          break;
        end
        new_rgb = vga_pkg::RGB_W'($urandom);
        if (new_rgb == pal_copy[idx])
          new_rgb = new_rgb ^ 18'h1;
        write_palette(idx, new_rgb);
      end
      wait_pixel(t_frame[i], t_line[i], t_col[i], ok);
      if (!ok)
      begin
        $display("Timeout waiting for the pixel of test %s", t_name[i]);
        timed_out = 1;
        break;
      end
      exp_rgb = pal_copy[idx];
      if (rgb_s !== exp_rgb)
      begin
        $display("ERR %s expected %05h actual %05h", t_name[i], exp_rgb, rgb_s);
        bad++;
      end
      // Neighbour in the same doubled pixel
      if (t_dbl[i] && rgb_s !== prev_rgb)
      begin
        $display("ERR %s expected %05h actual %05h", t_name[i], prev_rgb, rgb_s);
        bad++;
      end
      prev_rgb = rgb_s;
      errors += bad;
      if (bad != 0)
        fails++;
      $display("test %s %s", t_name[i], (bad == 0) ? "ok" : "failed");
    end

    if (geom_err != 0)
      fails++;
    $display("test line_geometry %s", (geom_err == 0) ? "ok" : "failed");
    if (mem_err != 0)
      fails++;
    $display("test memory_access %s", (mem_err == 0) ? "ok" : "failed");
    errors += geom_err + mem_err;
    $display("tests %0d failed %0d errors %0d", t_name.size() + 3, fails, errors);
    if (errors == 0 && !timed_out)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* dv/vga_linear_chk.sv */
/*
 * VGA linear scan-out protocol checker
 * Bound into the top level to watch the hsync pulse width, the strobe
 * cadence and the blanking of the picture during the sync pulses
 */

`timescale 1ns/10ps

module vga_linear_chk (
  input logic                      clk,
  input logic                      rst,
  input logic                      hsync_o,
  input logic                      vsync_o,
  input logic                      mem_stb_o,
  input logic                      de_o,
  input logic [vga_pkg::RGB_W-1:0] rgb_o
);

  // Low for exactly H_SYNC clocks once it falls
  hsync_width: assert property (@(posedge clk) disable iff (rst)
    $fell(hsync_o) |=> (!hsync_o) [*vga_pkg::H_SYNC-1] ##1 hsync_o)
    else $error("hsync pulse width differs from H_SYNC");

  // Never two strobes back to back
  stb_cadence: assert property (@(posedge clk) disable iff (rst)
    mem_stb_o |=> !mem_stb_o)
    else $error("mem_stb_o high on two consecutive cycles");

  // Sync pulses fall inside the blanking intervals
  sync_blank: assert property (@(posedge clk) disable iff (rst)
    (!hsync_o || !vsync_o) |-> (!de_o && (rgb_o == '0)))
    else $error("de_o or rgb_o active during a sync pulse");

endmodule

bind vga_linear_top vga_linear_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .hsync_o   (hsync_o),
  .vsync_o   (vsync_o),
  .mem_stb_o (mem_stb_o),
  .de_o      (de_o),
  .rgb_o     (rgb_o)
);

/* tb.f */
verilog/vga_pkg.sv
verilog/vga_sig_delay.sv
verilog/vga_crtc_ctrl.sv
verilog/vga_linear_fetch.sv
verilog/vga_palette_dac.sv
verilog/vga_linear_top.sv
dv/vga_linear_chk.sv
dv/tb_vga_linear.sv

/* verilog/vga_crtc_ctrl.sv */
/*
 * VGA CRT controller
 * Beam counters for the 640x480 raster, sync pulse decode and the
 * display enable of the 640x400 image window, plus the mode enable
 */

`timescale 1ns/10ps

module vga_crtc_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mode_en_i,
  output logic [vga_pkg::CNT_W-1:0] h_count_o,
  output logic [vga_pkg::CNT_W-1:0] v_count_o,
  output vga_pkg::sync_grp_t        sync_grp_o,
  output logic                      enable_o
);

  logic          enable_q;
  vga_pkg::cnt_t h_q;
  vga_pkg::cnt_t v_q;
  logic          h_wrap;
  logic          v_wrap;

  // Host mode enable, sampled once per clock
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      enable_q <= 1'b0;
    end
    else
    begin
      enable_q <= mode_en_i;
    end
  end

  // End of line and end of frame
  assign h_wrap = (h_q == vga_pkg::H_LAST);
  assign v_wrap = (v_q == vga_pkg::V_LAST);

  // Beam counters, frozen while the mode is off
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      h_q <= '0;
      v_q <= '0;
    end
    else if (enable_q)
    begin
      if (h_wrap)
      begin
        h_q <= '0;
        // Line advance at the end of each line
        if (v_wrap)
          v_q <= '0;
        else
          v_q <= v_q + vga_pkg::cnt_t'(1);
      end
      else
      begin
        h_q <= h_q + vga_pkg::cnt_t'(1);
      end
    end
  end

  // Sync pulses low inside their windows
  assign sync_grp_o.hsync = ~((h_q >= vga_pkg::HS_START) && (h_q < vga_pkg::HS_END));
  assign sync_grp_o.vsync = ~((v_q >= vga_pkg::VS_START) && (v_q < vga_pkg::VS_END));

  // Visible columns, only on the first 400 lines
  assign sync_grp_o.video_on = (h_q < vga_pkg::H_VIS_END) && (v_q < vga_pkg::V_ACT_END);

  assign h_count_o = h_q;
  assign v_count_o = v_q;
  assign enable_o  = enable_q;

endmodule

/* verilog/vga_linear_fetch.sv */
/*
 * VGA linear mode pixel fetch
 * Maps the beam position onto frame-buffer word reads, one read per
 * pixel pair, and returns one colour index per pixel together with the
 * sync group delayed by the same number of clocks
 */

`timescale 1ns/10ps

module vga_linear_fetch (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      enable_i,
  input  logic [vga_pkg::CNT_W-1:0] h_count_i,
  input  logic [vga_pkg::CNT_W-1:0] v_count_i,
  input  vga_pkg::sync_grp_t        sync_grp_i,
  output logic [vga_pkg::ADR_W-1:0] mem_adr_o,
  output logic                      mem_stb_o,
  input  logic [vga_pkg::DAT_W-1:0] mem_dat_i,
  output logic [vga_pkg::IDX_W-1:0] color_idx_o,
  output vga_pkg::sync_grp_t        sync_grp_o
);

  // Strobe tap is stage 1, data returns MEM_LAT stages later
  logic [vga_pkg::MEM_LAT+1:0] pipe_q;
  logic                        data_vld;

  // First address stage
  logic [9:0] row_addr_q;
  logic [6:0] col_addr_q;
  logic [1:0] plane0_q;

  // Second address stage
  logic [13:0] word_off_q;
  logic [1:0]  plane_q;

  logic [vga_pkg::IDX_W-1:0] color_idx;
  logic [vga_pkg::IDX_W-1:0] color_l;

  // Marks each even visible column, one read per pixel pair
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pipe_q <= '0;
    end
    else if (enable_i)
    begin
      pipe_q <= {pipe_q[vga_pkg::MEM_LAT:0], ~h_count_i[0] & sync_grp_i.video_on};
    end
  end

  assign mem_stb_o = pipe_q[1];
  assign data_vld  = pipe_q[vga_pkg::MEM_LAT+1];

  // Address pipeline, two stages to line up with the strobe
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      row_addr_q <= '0;
      col_addr_q <= '0;
      plane0_q   <= '0;
      word_off_q <= '0;
      plane_q    <= '0;
    end
    else if (enable_i)
    begin
      // Source row times five, i.e. 80 words per row in units of 16
      row_addr_q <= {v_count_i[8:1], 2'b00} + {2'b00, v_count_i[8:1]};
      col_addr_q <= h_count_i[9:3];
      plane0_q   <= h_count_i[2:1];
      // Row base plus upper column bits, low column bits appended
      word_off_q <= {row_addr_q + {7'd0, col_addr_q[6:4]}, col_addr_q[3:0]};
      plane_q    <= plane0_q;
    end
  end

  assign mem_adr_o = {word_off_q, plane_q, 1'b0};

  // Low byte straight from memory on the even pixel
  assign color_idx = data_vld ? mem_dat_i[vga_pkg::IDX_W-1:0] : color_l;

  // Held for the odd pixel of the pair
  always_ff @(posedge clk)
  begin
    if (enable_i)
    begin
      color_l <= color_idx;
    end
  end

  assign color_idx_o = color_idx;

  // Sync group follows the pixel through the fetch latency
  vga_sig_delay #(
    .payload_t (vga_pkg::sync_grp_t),
    .DEPTH     (vga_pkg::FETCH_LAT),
    .RST_VAL   (vga_pkg::SYNC_GRP_RST)
  ) u_sync_dly (
    .clk      (clk),
    .rst      (rst),
    .enable_i (enable_i),
    .d_i      (sync_grp_i),
    .q_o      (sync_grp_o)
  );

endmodule

/* verilog/vga_linear_top.sv */
/*
 * VGA linear 256-colour scan-out
 * CRT controller, linear fetch and palette DAC in a chain, with the
 * frame-buffer read port and the host palette write port
 */

`timescale 1ns/10ps

module vga_linear_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mode_en_i,
  output logic [vga_pkg::ADR_W-1:0] mem_adr_o,
  output logic                      mem_stb_o,
  input  logic [vga_pkg::DAT_W-1:0] mem_dat_i,
  input  logic                      pal_we_i,
  input  logic [vga_pkg::IDX_W-1:0] pal_idx_i,
  input  logic [vga_pkg::RGB_W-1:0] pal_dat_i,
  output logic [vga_pkg::RGB_W-1:0] rgb_o,
  output logic                      hsync_o,
  output logic                      vsync_o,
  output logic                      de_o
);

  logic [vga_pkg::CNT_W-1:0] h_count;
  logic [vga_pkg::CNT_W-1:0] v_count;
  logic                      enable;
  vga_pkg::sync_grp_t        crtc_grp;
  vga_pkg::sync_grp_t        fetch_grp;
  logic [vga_pkg::IDX_W-1:0] color_idx;

  // Raster timing
  vga_crtc_ctrl u_crtc (
    .clk        (clk),
    .rst        (rst),
    .mode_en_i  (mode_en_i),
    .h_count_o  (h_count),
    .v_count_o  (v_count),
    .sync_grp_o (crtc_grp),
    .enable_o   (enable)
  );

  // Frame-buffer reads and colour index
  vga_linear_fetch u_fetch (
    .clk         (clk),
    .rst         (rst),
    .enable_i    (enable),
    .h_count_i   (h_count),
    .v_count_i   (v_count),
    .sync_grp_i  (crtc_grp),
    .mem_adr_o   (mem_adr_o),
    .mem_stb_o   (mem_stb_o),
    .mem_dat_i   (mem_dat_i),
    .color_idx_o (color_idx),
    .sync_grp_o  (fetch_grp)
  );

  // Index to RGB
  vga_palette_dac u_pal (
    .clk         (clk),
    .rst         (rst),
    .enable_i    (enable),
    .pal_we_i    (pal_we_i),
    .pal_idx_i   (pal_idx_i),
    .pal_dat_i   (pal_dat_i),
    .color_idx_i (color_idx),
    .sync_grp_i  (fetch_grp),
    .rgb_o       (rgb_o),
    .hsync_o     (hsync_o),
    .vsync_o     (vsync_o),
    .de_o        (de_o)
  );

endmodule

/* verilog/vga_palette_dac.sv */
/*
 * VGA palette DAC
 * 256 x 18-bit colour table written by the host, looked up once per
 * pixel with a registered read, output blanked outside the display window
 */

`timescale 1ns/10ps

module vga_palette_dac (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      enable_i,
  input  logic                      pal_we_i,
  input  logic [vga_pkg::IDX_W-1:0] pal_idx_i,
  input  logic [vga_pkg::RGB_W-1:0] pal_dat_i,
  input  logic [vga_pkg::IDX_W-1:0] color_idx_i,
  input  vga_pkg::sync_grp_t        sync_grp_i,
  output logic [vga_pkg::RGB_W-1:0] rgb_o,
  output logic                      hsync_o,
  output logic                      vsync_o,
  output logic                      de_o
);

  logic [vga_pkg::RGB_W-1:0] pal_mem [vga_pkg::PAL_DEPTH];
  logic [vga_pkg::RGB_W-1:0] rgb_q;
  vga_pkg::sync_grp_t        grp_q;

  // Host write, visible to lookups from the next clock on
  always_ff @(posedge clk)
  begin
    if (pal_we_i)
    begin
      pal_mem[pal_idx_i] <= pal_dat_i;
    end
  end

  // Lookup register
  always_ff @(posedge clk)
  begin
    if (enable_i)
    begin
      rgb_q <= pal_mem[color_idx_i];
    end
  end

  // Syncs and enable kept in step with the lookup
  vga_sig_delay #(
    .payload_t (vga_pkg::sync_grp_t),
    .DEPTH     (vga_pkg::PAL_LAT),
    .RST_VAL   (vga_pkg::SYNC_GRP_RST)
  ) u_sync_dly (
    .clk      (clk),
    .rst      (rst),
    .enable_i (enable_i),
    .d_i      (sync_grp_i),
    .q_o      (grp_q)
  );

  // Black outside the window
  assign rgb_o   = grp_q.video_on ? rgb_q : '0;
  assign hsync_o = grp_q.hsync;
  assign vsync_o = grp_q.vsync;
  assign de_o    = grp_q.video_on;

endmodule

/* verilog/vga_pkg.sv */
/*
 * VGA linear scan-out shared definitions
 * Raster timing for 640x480 at one pixel per clock, field widths of the
 * memory and palette ports, and pipeline latencies of the subsystem
 */

package vga_pkg;

  // Horizontal timing in pixels
  localparam int H_VISIBLE = 640;
  localparam int H_FRONT   = 16;
  localparam int H_SYNC    = 96;
  localparam int H_TOTAL   = 800;

  // Vertical timing in lines
  localparam int V_VISIBLE = 480;
  localparam int V_FRONT   = 10;
  localparam int V_SYNC    = 2;
  localparam int V_TOTAL   = 525;

  // Lines carrying the line-doubled 320x200 picture
  localparam int V_ACTIVE  = 400;

  // Field widths
  localparam int CNT_W     = 10;
  localparam int ADR_W     = 17;
  localparam int DAT_W     = 16;
  localparam int IDX_W     = 8;
  localparam int RGB_W     = 18;
  localparam int PAL_DEPTH = 2 ** IDX_W;

  // Latencies in clocks
  localparam int MEM_LAT   = 3;
  localparam int FETCH_LAT = 5;
  localparam int PAL_LAT   = 1;
  localparam int TOP_LAT   = FETCH_LAT + PAL_LAT;

  // Beam counter type and the decode points derived from the timing above
  typedef logic [CNT_W-1:0] cnt_t;

  localparam cnt_t H_LAST    = cnt_t'(H_TOTAL - 1);
  localparam cnt_t V_LAST    = cnt_t'(V_TOTAL - 1);
  localparam cnt_t H_VIS_END = cnt_t'(H_VISIBLE);
  localparam cnt_t V_ACT_END = cnt_t'(V_ACTIVE);
  localparam cnt_t HS_START  = cnt_t'(H_VISIBLE + H_FRONT);
  localparam cnt_t HS_END    = cnt_t'(H_VISIBLE + H_FRONT + H_SYNC);
  localparam cnt_t VS_START  = cnt_t'(V_VISIBLE + V_FRONT);
  localparam cnt_t VS_END    = cnt_t'(V_VISIBLE + V_FRONT + V_SYNC);

  // Sync and enable group, both syncs active low
  typedef struct packed {
    logic hsync;
    logic video_on;
    logic vsync;
  } sync_grp_t;

  // Idle group value: syncs high, video off
  localparam sync_grp_t SYNC_GRP_RST = '{hsync: 1'b1, video_on: 1'b0, vsync: 1'b1};

endpackage

/* verilog/vga_sig_delay.sv */
/*
 * Fixed-depth delay line
 * Shift register of DEPTH stages for any payload type, stepping only
 * while enabled and resetting every stage to RST_VAL
 */

`timescale 1ns/10ps

module vga_sig_delay #(
  parameter type      payload_t = logic,
  parameter int       DEPTH     = 1,
  parameter payload_t RST_VAL   = '0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     enable_i,
  input  payload_t d_i,
  output payload_t q_o
);

  payload_t stage_q [DEPTH];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < DEPTH; i++)
        stage_q[i] <= RST_VAL;
    end
    else if (enable_i)
    begin
      stage_q[0] <= d_i;
      // Older samples move one stage on
      for (int i = 1; i < DEPTH; i++)
        stage_q[i] <= stage_q[i-1];
    end
  end

  // Oldest stage
  assign q_o = stage_q[DEPTH-1];

endmodule
